/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert
TOP       ?= fetch_tb
FILELIST  ?= fetch.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "Result: FAILED" $(LOG); then exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* fetch.f */
src/fetch_pkg.sv
src/instr_ram.sv
src/pc_unit.sv
src/prog_loader.sv
src/ram_arbiter.sv
src/fetch_top.sv
tests/fetch_checker.sv
tests/fetch_tb.sv

/* src/fetch_pkg.sv */
`default_nettype none

package fetch_pkg;

   // Widths fixed by the instruction set
   localparam int WORD_W    = 32;
   localparam int PC_W      = 32;
   localparam int ADDR_W    = 10;             // Word address into the instruction RAM
   localparam int WADDR_LSB = 2;              // Byte offset bits dropped from the PC
   localparam int RAM_DEPTH = 1024;           // Matches 2**ADDR_W so the pointer wraps

   typedef logic [WORD_W-1:0] word_t;         // Instruction or data word
   typedef logic [PC_W-1:0]   pc_t;           // Byte address of an instruction
   typedef logic [ADDR_W-1:0] waddr_t;        // Word address, PC[11:2]

   // sll $0 $0 0 encodes as all zeros
   localparam word_t NOP_WORD = 32'h0000_0000;
   localparam pc_t   RESET_PC = 32'h0000_0000; // First fetch address
   localparam pc_t   PC_STEP  = 32'd4;         // One instruction

   // Request on the single RAM port
   typedef struct packed {
      logic   we;                             // Write enable, read otherwise
      waddr_t addr;                           // Word address
      word_t  wdata;                          // Write data
   } ram_req_t;

   // IF/ID contents seen by decode
   typedef struct packed {
      logic  valid;                           // Low for flushed or lost fetches
      pc_t   pc;                              // PC of instr
      word_t instr;                           // Fetched instruction
   } fetch_out_t;

endpackage

`default_nettype wire

/* src/fetch_top.sv */
`default_nettype none

// Instruction fetch front end
module fetch_top (
   input  wire logic              i_clk,
   input  wire logic              i_rst,
   input  wire logic              i_stall,        // From hazard logic
   input  wire logic              i_flush,
   input  wire logic              i_redirect,
   input  wire fetch_pkg::pc_t    i_target,
   input  wire logic              i_load_start,
   input  wire fetch_pkg::waddr_t i_load_base,
   input  wire logic              i_load_strobe,
   input  wire fetch_pkg::word_t  i_load_word,
   output fetch_pkg::fetch_out_t  o_fetch         // IF/ID contents
);

   fetch_pkg::ram_req_t load_req;                 // Loader write
   fetch_pkg::ram_req_t ram_req;                  // Granted port request
   fetch_pkg::waddr_t   fetch_addr;
   fetch_pkg::pc_t      if_pc;
   fetch_pkg::word_t    instr;
   logic                fetch_lost;
   logic                valid;

   prog_loader u_loader (
      .i_clk    (i_clk),
      .i_rst    (i_rst),
      .i_start  (i_load_start),
      .i_base   (i_load_base),
      .i_strobe (i_load_strobe),
      .i_word   (i_load_word),
      .o_req    (load_req)
   );

   pc_unit u_pc (
      .i_clk        (i_clk),
      .i_rst        (i_rst),
      .i_stall      (i_stall),
      .i_flush      (i_flush),
      .i_fetch_lost (fetch_lost),
      .i_redirect   (i_redirect),
      .i_target     (i_target),
      .o_fetch_addr (fetch_addr),
      .o_if_pc      (if_pc)
   );

   ram_arbiter u_arb (
      .i_load_req   (load_req),
      .i_fetch_addr (fetch_addr),
      .i_clk        (i_clk),
      .i_rst        (i_rst),
      .i_stall      (i_stall),
      .i_flush      (i_flush),
      .o_ram_req    (ram_req),
      .o_fetch_lost (fetch_lost),
      .o_valid      (valid)
   );

   instr_ram u_ram (
      .i_clk   (i_clk),
      .i_rst   (i_rst),
      .i_req   (ram_req),
      .i_hold  (i_stall),
      .i_flush (i_flush),
      .o_instr (instr)
   );

   assign o_fetch = '{valid: valid, pc: if_pc, instr: instr};

endmodule

`default_nettype wire

/* src/instr_ram.sv */
`default_nettype none

// Single-port write-first instruction RAM
// The read register doubles as the instruction half of IF/ID
module instr_ram (
   input  wire logic                i_clk,
   input  wire logic                i_rst,
   input  wire fetch_pkg::ram_req_t i_req,    // Arbitrated port request
   input  wire logic                i_hold,   // Stall, IF/ID write disabled
   input  wire logic                i_flush,  // Load a NOP into IF/ID
   output fetch_pkg::word_t         o_instr
);

   // Array starts cleared, the loader fills it
   fetch_pkg::word_t mem [fetch_pkg::RAM_DEPTH] = '{default: fetch_pkg::NOP_WORD};
   fetch_pkg::word_t rd_q;                    // Registered read data

   // Array write
   always_ff @(posedge i_clk) begin
      if (i_req.we) begin
         mem[i_req.addr] <= i_req.wdata;
      end
   end

   // Read register, priority is write, flush, stall, read
   always_ff @(posedge i_clk) begin
      if (i_rst) begin
         rd_q <= fetch_pkg::NOP_WORD;         // Decode sees a NOP out of reset
      end else if (i_req.we) begin
         rd_q <= i_req.wdata;                 // Write-first, output follows the written word
      end else if (i_flush) begin
         rd_q <= fetch_pkg::NOP_WORD;         // Squash the fetched slot
      end else if (!i_hold) begin
         rd_q <= mem[i_req.addr];
      end
      // Stalled cycles keep the old instruction
   end

   assign o_instr = rd_q;

endmodule

`default_nettype wire

/* src/pc_unit.sv */
`default_nettype none

// Program counter with redirect, stall hold and the IF/ID PC copy
module pc_unit (
   input  wire logic           i_clk,
   input  wire logic           i_rst,
   input  wire logic           i_stall,       // IF/ID hold
   input  wire logic           i_flush,       // Fetched slot is squashed, PC keeps moving
   input  wire logic           i_fetch_lost,  // Loader took the RAM port this cycle
   input  wire logic           i_redirect,    // Branch or jump taken
   input  wire fetch_pkg::pc_t i_target,      // Redirect byte address
   output fetch_pkg::waddr_t   o_fetch_addr,  // Word address of the current fetch
   output fetch_pkg::pc_t      o_if_pc        // PC of the instruction in IF/ID
);

   fetch_pkg::pc_t pc_q;                      // Address being fetched now
   fetch_pkg::pc_t if_pc_q;                   // Follows the RAM read register
   fetch_pkg::pc_t pc_seq;                    // Sequential next PC
   logic           advance;                   // Fetch completed this cycle

   // Same update rule as the RAM read register
   // A lost fetch holds, a flush still consumes the slot, a stall holds
   assign advance = !i_fetch_lost && (i_flush || !i_stall);

   assign pc_seq = pc_q + fetch_pkg::PC_STEP;

   always_ff @(posedge i_clk) begin
      if (i_rst) begin
         pc_q <= fetch_pkg::RESET_PC;
      end else if (i_redirect) begin
         pc_q <= i_target;                    // Taken even while stalled
      end else if (advance) begin
         pc_q <= pc_seq;
      end
   end

   // PC copy for IF/ID, captured with the instruction it belongs to
   always_ff @(posedge i_clk) begin
      if (i_rst) begin
         if_pc_q <= fetch_pkg::RESET_PC;
      end else if (advance) begin
         if_pc_q <= pc_q;
      end
   end

   // PC[11:2] indexes the 1024-word RAM
   assign o_fetch_addr = pc_q[fetch_pkg::WADDR_LSB +: fetch_pkg::ADDR_W];
   assign o_if_pc      = if_pc_q;

endmodule

`default_nettype wire

/* src/prog_loader.sv */
`default_nettype none

// Writes strobed words into the RAM at consecutive word addresses
module prog_loader (
   input  wire logic              i_clk,
   input  wire logic              i_rst,
   input  wire logic              i_start,    // Load a new base address
   input  wire fetch_pkg::waddr_t i_base,
   input  wire logic              i_strobe,   // One word per strobe
   input  wire fetch_pkg::word_t  i_word,
   output fetch_pkg::ram_req_t    o_req       // Write request, valid when we is high
);

   fetch_pkg::waddr_t ptr_q;                  // Next write address
   fetch_pkg::waddr_t wr_addr;                // Address used this cycle

   // A start in the same cycle as a strobe writes at the new base
   assign wr_addr = i_start ? i_base : ptr_q;

   always_ff @(posedge i_clk) begin
      if (i_rst) begin
         ptr_q <= '0;
      end else if (i_strobe) begin
         ptr_q <= wr_addr + fetch_pkg::waddr_t'(1); // Wraps at the RAM depth
      end else if (i_start) begin
         ptr_q <= i_base;
      end
   end

   // Request goes out in the strobe cycle
   always_comb begin
      o_req.we    = i_strobe;
      o_req.addr  = wr_addr;
      o_req.wdata = i_word;
   end

endmodule

`default_nettype wire

/* src/ram_arbiter.sv */
`default_nettype none

// Fixed priority arbiter for the RAM port, loader over fetch
// Also keeps the IF/ID valid bit
module ram_arbiter (
   input  wire fetch_pkg::ram_req_t i_load_req,   // From the loader
   input  wire fetch_pkg::waddr_t   i_fetch_addr, // From the PC unit, always requesting
   input  wire logic                i_clk,
   input  wire logic                i_rst,
   input  wire logic                i_stall,
   input  wire logic                i_flush,
   output fetch_pkg::ram_req_t      o_ram_req,
   output logic                     o_fetch_lost, // Fetch dropped this cycle
   output logic                     o_valid       // IF/ID valid
);

   logic valid_q;

   // Loader write passes through, otherwise a read at the PC
   always_comb begin
      if (i_load_req.we) begin
         o_ram_req = i_load_req;
      end else begin
         o_ram_req.we    = 1'b0;
         o_ram_req.addr  = i_fetch_addr;
         o_ram_req.wdata = '0;                // Unused on reads
      end
   end

   assign o_fetch_lost = i_load_req.we;

   // Same priority as the RAM read register
   always_ff @(posedge i_clk) begin
      if (i_rst) begin
         valid_q <= 1'b0;
      end else if (o_fetch_lost || i_flush) begin
         valid_q <= 1'b0;                     // Written word or NOP is not an instruction to run
      end else if (!i_stall) begin
         valid_q <= 1'b1;
      end
   end

   assign o_valid = valid_q;

endmodule

`default_nettype wire

/* tests/fetch_checker.sv */
`default_nettype none

// Concurrent checks on the IF/ID output of the fetch front end
module fetch_checker (
   input wire logic                  i_clk,
   input wire logic                  i_rst,
   input wire logic                  i_stall,
   input wire logic                  i_flush,
   input wire logic                  i_load_strobe,  // Loader write, fetch is lost
   input wire fetch_pkg::fetch_out_t i_fetch         // IF/ID contents
);

   // A squashed or lost fetch never leaves a valid instruction
   a_kill_clears_valid : assert property (
      @(posedge i_clk) disable iff (i_rst)
      (i_flush || i_load_strobe) |=> !i_fetch.valid
   ) else $error("IF/ID valid set after a flush or a loader write");

   // Flush without a write puts a NOP into IF/ID
   a_flush_loads_nop : assert property (
      @(posedge i_clk) disable iff (i_rst)
      (i_flush && !i_load_strobe) |=> (i_fetch.instr == fetch_pkg::NOP_WORD)
   ) else $error("IF/ID instruction is not a NOP after a flush");

   // Plain stall keeps the whole register
   a_stall_holds : assert property (
      @(posedge i_clk) disable iff (i_rst)
      (i_stall && !i_flush && !i_load_strobe) |=> $stable(i_fetch)
   ) else $error("IF/ID contents changed during a stall");

   a_reset_invalid : assert property (
      @(posedge i_clk) i_rst |=> !i_fetch.valid
   ) else $error("IF/ID valid set after reset");

endmodule

`default_nettype wire

/* tests/fetch_tb.sv */
`default_nettype none

module fetch_tb;

   localparam int CLK_PERIOD   = 100;
   localparam int RESET_CYCLES = 16;
   localparam int TEST_CYCLES  = 3 + 126 + 102 + 81 + 103;  // Per test, idle cycles included
   localparam int MARGIN       = 100;

   logic                  i_clk;
   logic                  i_rst;
   logic                  i_stall;
   logic                  i_flush;
   logic                  i_redirect;
   fetch_pkg::pc_t        i_target;
   logic                  i_load_start;
   fetch_pkg::waddr_t     i_load_base;
   logic                  i_load_strobe;
   fetch_pkg::word_t      i_load_word;
   fetch_pkg::fetch_out_t o_fetch;

   // Reference model state
   fetch_pkg::word_t      ref_mem [fetch_pkg::RAM_DEPTH];
   fetch_pkg::pc_t        ref_pc;                 // Address fetched this cycle
   fetch_pkg::fetch_out_t ref_out;                // Expected IF/ID contents
   fetch_pkg::waddr_t     ref_ptr;                // Loader pointer

   int    seed = 32'h77d9;
   string test_name = "reset_state";
   int    checks = 0;
   int    test_errors = 0;
   int    total_checks = 0;
   int    total_errors = 0;
   logic  checking = 1'b0;                        // Compare only once out of reset

   fetch_top u_dut (
      .i_clk         (i_clk),
      .i_rst         (i_rst),
      .i_stall       (i_stall),
      .i_flush       (i_flush),
      .i_redirect    (i_redirect),
      .i_target      (i_target),
      .i_load_start  (i_load_start),
      .i_load_base   (i_load_base),
      .i_load_strobe (i_load_strobe),
      .i_load_word   (i_load_word),
      .o_fetch       (o_fetch)
   );

   bind fetch_top fetch_checker u_checker (
      .i_clk         (i_clk),
      .i_rst         (i_rst),
      .i_stall       (i_stall),
      .i_flush       (i_flush),
      .i_load_strobe (i_load_strobe),
      .i_fetch       (o_fetch)
   );

   initial begin
      i_clk = 1'b0;
      forever #(CLK_PERIOD / 2) i_clk = ~i_clk;
   end

   // Next IF/ID contents, priority write, flush, stall, fetch
   function automatic fetch_pkg::fetch_out_t next_fetch(
      input fetch_pkg::fetch_out_t cur,
      input fetch_pkg::pc_t        pc,
      input fetch_pkg::word_t      rd_word,
      input logic                  wr,
      input logic                  flush,
      input logic                  stall,
      input fetch_pkg::word_t      wr_word
   );
      fetch_pkg::fetch_out_t nxt;
      nxt = cur;
      if (wr) begin
         nxt.valid = 1'b0;                        // Written word shows, PC copy holds
         nxt.instr = wr_word;
      end else if (flush) begin
         nxt = '{valid: 1'b0, pc: pc, instr: fetch_pkg::NOP_WORD};
      end else if (!stall) begin
         nxt = '{valid: 1'b1, pc: pc, instr: rd_word};
      end
      return nxt;
   endfunction

   // Model update, inputs are stable since the falling edge
   always @(posedge i_clk) begin : ref_model
      fetch_pkg::waddr_t wr_addr;
      wr_addr = i_load_start ? i_load_base : ref_ptr;
      if (i_rst) begin
         ref_out = '{valid: 1'b0, pc: fetch_pkg::RESET_PC, instr: fetch_pkg::NOP_WORD};
         ref_pc  = fetch_pkg::RESET_PC;
         ref_ptr = '0;
      end else begin
         ref_out = next_fetch(ref_out, ref_pc, ref_mem[ref_pc[11:2]], i_load_strobe,
                              i_flush, i_stall, i_load_word);
         if (i_redirect) begin
            ref_pc = i_target;                    // Taken even when stalled
         end else if (!i_load_strobe && (i_flush || !i_stall)) begin
            ref_pc = ref_pc + 32'd4;
         end
         if (i_load_strobe) begin
            ref_mem[wr_addr] = i_load_word;
            ref_ptr = wr_addr + 10'd1;            // Wraps at 1024
         end else if (i_load_start) begin
            ref_ptr = i_load_base;
         end
      end
   end

   // Compare IF/ID with the model at every falling edge
   always @(negedge i_clk) begin
      if (checking) begin
         checks++;
         assert (o_fetch === ref_out) else begin
            $display("** Error %s: expected v=%b pc=%h instr=%h, actual v=%b pc=%h instr=%h",
                     test_name, ref_out.valid, ref_out.pc, ref_out.instr,
                     o_fetch.valid, o_fetch.pc, o_fetch.instr);
            test_errors++;
         end
      end
   end

   initial begin
      #((RESET_CYCLES + TEST_CYCLES + MARGIN) * CLK_PERIOD);
      $display("Timeout: the tests did not finish within %0d cycles",
               RESET_CYCLES + TEST_CYCLES + MARGIN);
      $display("Result: FAILED");
      $finish;
   end

   task automatic check_field(input string what, input logic [31:0] exp_val,
                              input logic [31:0] act_val);
      checks++;
      assert (act_val === exp_val) else begin
         $display("** Error %s: %s expected %h actual %h", test_name, what, exp_val, act_val);
         test_errors++;
      end
   endtask

   task automatic drive_cycle(input logic stall, input logic flush, input logic redirect,
                              input fetch_pkg::pc_t target, input logic start,
                              input fetch_pkg::waddr_t base, input logic strobe,
                              input fetch_pkg::word_t word);
      @(negedge i_clk);
      i_stall       = stall;
      i_flush       = flush;
      i_redirect    = redirect;
      i_target      = target;
      i_load_start  = start;
      i_load_base   = base;
      i_load_strobe = strobe;
      i_load_word   = word;
   endtask

   task automatic drive_idle();
      drive_cycle(1'b0, 1'b0, 1'b0, '0, 1'b0, '0, 1'b0, '0);
   endtask

   // Idle cycle lets the last result reach the compare
   task automatic end_test();
      drive_idle();
      #1;
      $display("Test %s: %0d checks, %0d errors", test_name, checks, test_errors);
      total_checks += checks;
      total_errors += test_errors;
      checks = 0;
      test_errors = 0;
   endtask

   function automatic logic one_in(input logic [31:0] n);
      logic [31:0] r;
      r = $random(seed);
      return (r % n) == 32'd0;
   endfunction

   function automatic fetch_pkg::word_t rand_word();
      return $random(seed);
   endfunction

   // Word aligned, inside the 64 loaded words
   function automatic fetch_pkg::pc_t rand_target();
      logic [31:0] r;
      r = $random(seed);
      return {24'd0, r[5:0], 2'b00};
   endfunction

   initial begin : stimulus
      logic           st;
      logic           rd;
      fetch_pkg::pc_t tgt;
      i_rst = 1'b1;
      i_stall = 1'b0;
      i_flush = 1'b0;
      i_redirect = 1'b0;
      i_target = '0;
      i_load_start = 1'b0;
      i_load_base = '0;
      i_load_strobe = 1'b0;
      i_load_word = '0;
      foreach (ref_mem[a]) ref_mem[a] = '0;       // RAM starts cleared
      repeat (RESET_CYCLES) @(posedge i_clk);
      @(negedge i_clk);
      i_rst = 1'b0;
      #1;
      check_field("reset valid", 32'd0, 32'(o_fetch.valid));
      check_field("reset instr", fetch_pkg::NOP_WORD, o_fetch.instr);
      checking = 1'b1;
      @(negedge i_clk);
      check_field("first fetch valid", 32'd1, 32'(o_fetch.valid));
      check_field("first fetch pc", fetch_pkg::RESET_PC, o_fetch.pc);
      end_test();

      test_name = "load_run";
      for (int i = 0; i < 64; i++) begin
         drive_cycle(1'b0, 1'b0, 1'b0, '0, (i == 0), '0, 1'b1, rand_word());
      end
      drive_cycle(1'b0, 1'b0, 1'b1, fetch_pkg::RESET_PC, 1'b0, '0, 1'b0, '0);
      repeat (60) drive_idle();
      end_test();

      test_name = "stall_flush";
      drive_cycle(1'b0, 1'b0, 1'b1, fetch_pkg::RESET_PC, 1'b0, '0, 1'b0, '0);
      for (int i = 0; i < 100; i++) begin
         drive_cycle(one_in(4), one_in(8), 1'b0, '0, 1'b0, '0, 1'b0, '0);
      end
      end_test();

      test_name = "redirect";
      for (int i = 0; i < 80; i++) begin
         st  = one_in(5);
         rd  = one_in(8);
         tgt = rand_target();
         if (i == 10) begin
            st = 1'b1;                            // Branch resolved during a stall
            rd = 1'b1;
         end
         drive_cycle(st, 1'b0, rd, tgt, 1'b0, '0, 1'b0, '0);
      end
      end_test();

      test_name = "load_during_fetch";
      drive_cycle(1'b0, 1'b0, 1'b1, 32'd128, 1'b0, '0, 1'b0, '0);
      for (int i = 0; i < 60; i++) begin
         drive_cycle(1'b0, 1'b0, 1'b0, '0, (i == 0), 10'd32, (i == 0) || one_in(3),
                     rand_word());
      end
      drive_cycle(1'b0, 1'b0, 1'b1, 32'd128, 1'b0, '0, 1'b0, '0); // Refetch new words
      repeat (40) drive_idle();
      end_test();

      $display("Total: %0d checks, %0d errors", total_checks, total_errors);
      if (total_errors == 0) begin
         $display("Result: PASSED");
      end else begin
         $display("Result: FAILED");
      end
      $finish;
   end

endmodule

`default_nettype wire
